// File: l1_mem_pkg.sv
package l1_mem_pkg;

	// sizes of one memory transfer
	localparam int LINE_BYTES = 32;
	localparam int OFFSET_BITS = $clog2(LINE_BYTES);
	localparam int WORD_BITS = 32;
	localparam int LINE_BITS = LINE_BYTES * 8;

	typedef logic [WORD_BITS-1:0] rv32i_word;
	typedef logic [LINE_BITS-1:0] line_t; // eight words

	// byte address, seen flat or split into line number and offset
	typedef union packed {
		rv32i_word flat;
		struct packed {
			logic [WORD_BITS-OFFSET_BITS-1:0] line_num;
			logic [OFFSET_BITS-1:0] offset;
		} parts;
	} line_addr_u;

	// transaction tag, doubles as the arbiter's response select
	typedef enum logic [1:0] {
		xact_read_a = 2'd0,  // icache demand read
		xact_read_b = 2'd1,  // dcache demand read
		xact_write_b = 2'd2, // eviction write
		xact_pre_a = 2'd3    // instruction prefetch
	} xact_kind_e;

endpackage : l1_mem_pkg

// File: mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if import l1_mem_pkg::*; ();

	// request side, held until resp
	logic read;
	logic write;
	rv32i_word addr;
	line_t wdata;

	// response side, rdata valid with the resp pulse
	line_t rdata;
	logic resp;

	modport requester (
		output read,
		output write,
		output addr,
		output wdata,
		input rdata,
		input resp
	);

	modport server (
		input read,
		input write,
		input addr,
		input wdata,
		output rdata,
		output resp
	);

endinterface : mem_port_if

// File: l1_arbiter.sv
`timescale 1ns/1ps

module l1_arbiter import l1_mem_pkg::*; (
	input logic clk,
	input logic rst_n,

	mem_port_if.server i_demand, // icache demand read
	mem_port_if.server i_pre,    // next-line prefetch read
	mem_port_if.server d_write,  // eviction buffer drain
	mem_port_if.server d_read,   // dcache demand read

	output logic pmem_read,
	output logic pmem_write,
	output rv32i_word pmem_address,
	output line_t pmem_wdata,
	input line_t pmem_rdata,
	input logic pmem_resp
);

	enum logic [2:0] {
		idle,
		latch_a,
		latch_w,
		latch_b,
		latch_p,
		reading,
		writing,
		finish
	} state, next_state;

	line_addr_u addr_sel;
	xact_kind_e kind_sel;
	logic latch_en;

	rv32i_word addr_q;
	line_t wdata_q;
	line_t rdata_q;
	xact_kind_e kind_q;

	// pick the request for the current latch state
	always_comb begin
		addr_sel.flat = i_demand.addr;
		kind_sel = xact_read_a;
		latch_en = 1'b1;
		case (state)
			latch_a: ;
			latch_w: begin
				addr_sel.flat = d_write.addr;
				kind_sel = xact_write_b;
			end
			latch_b: begin
				addr_sel.flat = d_read.addr;
				kind_sel = xact_read_b;
			end
			latch_p: begin
				addr_sel.flat = i_pre.addr;
				kind_sel = xact_pre_a;
			end
			default: latch_en = 1'b0;
		endcase
		addr_sel.parts.offset = '0; // memory only sees whole lines
	end

	// fixed priority, new work only from idle
	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (i_demand.read)
					next_state = latch_a;
				else if (d_write.write)
					next_state = latch_w;
				else if (d_read.read)
					next_state = latch_b;
				else if (i_pre.read)
					next_state = latch_p;
			end
			latch_a,
			latch_b,
			latch_p: next_state = reading;
			latch_w: next_state = writing;
			reading: begin
				if (pmem_resp)
					next_state = finish;
			end
			writing: begin
				if (pmem_resp)
					next_state = finish;
			end
			finish: next_state = idle;
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= idle;
		else
			state <= next_state;
	end

	// transaction registers
	always_ff @(posedge clk) begin
		if (latch_en) begin
			addr_q <= addr_sel.flat;
			kind_q <= kind_sel;
		end
		if (state == latch_w)
			wdata_q <= d_write.wdata;
		if (state == reading && pmem_resp)
			rdata_q <= pmem_rdata; // captured on the resp edge
	end

	assign pmem_read = (state == reading);
	assign pmem_write = (state == writing);
	assign pmem_address = addr_q;
	assign pmem_wdata = wdata_q;

	// one read line shared by every read port
	assign i_demand.rdata = rdata_q;
	assign i_pre.rdata = rdata_q;
	assign d_read.rdata = rdata_q;
	assign d_write.rdata = '0; // writes return no data

	// response goes only to the owner of the finished transaction
	assign i_demand.resp = (state == finish) && (kind_q == xact_read_a);
	assign d_read.resp = (state == finish) && (kind_q == xact_read_b);
	assign d_write.resp = (state == finish) && (kind_q == xact_write_b);
	assign i_pre.resp = (state == finish) && (kind_q == xact_pre_a);

endmodule : l1_arbiter

// File: eviction_write_buffer.sv
`timescale 1ns/1ps

module eviction_write_buffer import l1_mem_pkg::*; (
	input logic clk,
	input logic rst_n,

	mem_port_if.server dcache,
	mem_port_if.requester arb_write,
	mem_port_if.requester arb_read
);

	logic full;
	logic resp_q; // local response pulse
	line_addr_u buf_addr;
	line_t buf_line;

	line_addr_u req_addr;
	logic line_match;
	logic local_hit;
	logic take_write;

	assign req_addr.flat = dcache.addr;
	assign line_match = (req_addr.parts.line_num == buf_addr.parts.line_num);

	// dirty line still here, memory copy is stale
	assign local_hit = dcache.read && full && line_match;

	// slot frees on the drain response, then takes the waiting line
	assign take_write = dcache.write && !resp_q && (!full || arb_write.resp);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full <= 1'b0;
			resp_q <= 1'b0;
		end else begin
			resp_q <= take_write || (local_hit && !resp_q);
			if (take_write)
				full <= 1'b1;
			else if (arb_write.resp)
				full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take_write) begin
			buf_addr <= req_addr;
			buf_line <= dcache.wdata;
		end
	end

	// drain, dropped for one cycle after each ack
	assign arb_write.read = 1'b0;
	assign arb_write.write = full && !resp_q;
	assign arb_write.addr = buf_addr.flat;
	assign arb_write.wdata = buf_line;

	// misses go straight through to memory
	assign arb_read.read = dcache.read && !local_hit && !resp_q;
	assign arb_read.write = 1'b0;
	assign arb_read.addr = dcache.addr;
	assign arb_read.wdata = '0;

	assign dcache.resp = resp_q || arb_read.resp;
	assign dcache.rdata = resp_q ? buf_line : arb_read.rdata; // buffered line on a hit

endmodule : eviction_write_buffer

// File: next_line_prefetcher.sv
`timescale 1ns/1ps

module next_line_prefetcher import l1_mem_pkg::*; (
	input logic clk,
	input logic rst_n,

	mem_port_if.server icache,
	mem_port_if.requester arb_demand,
	mem_port_if.requester arb_pre
);

	logic pf_valid;   // pf_line holds the line at pf_addr
	logic pf_pending; // prefetch requested, not yet filled
	logic resp_q;
	line_addr_u pf_addr;
	line_t pf_line;

	line_addr_u req_addr;
	line_addr_u next_addr;
	logic hit;

	assign req_addr.flat = icache.addr;

	// line after the current miss, aligned
	always_comb begin
		next_addr.flat = '0;
		next_addr.parts.line_num = req_addr.parts.line_num + 1'b1;
	end

	assign hit = icache.read && pf_valid &&
		(req_addr.parts.line_num == pf_addr.parts.line_num);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pf_valid <= 1'b0;
			pf_pending <= 1'b0;
			resp_q <= 1'b0;
		end else begin
			resp_q <= hit && !resp_q;
			if (arb_demand.resp) begin
				// a finished miss starts the next prefetch
				pf_pending <= 1'b1;
				pf_valid <= 1'b0;
			end else if (arb_pre.resp) begin
				pf_pending <= 1'b0;
				pf_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (arb_demand.resp)
			pf_addr <= next_addr; // miss address still held here
		if (arb_pre.resp)
			pf_line <= arb_pre.rdata;
	end

	// demand path, bypassed on a buffer hit
	assign arb_demand.read = icache.read && !hit && !resp_q;
	assign arb_demand.write = 1'b0;
	assign arb_demand.addr = icache.addr;
	assign arb_demand.wdata = '0;

	// prefetch path, lowest priority at the arbiter
	assign arb_pre.read = pf_pending;
	assign arb_pre.write = 1'b0;
	assign arb_pre.addr = pf_addr.flat;
	assign arb_pre.wdata = '0;

	assign icache.resp = resp_q || arb_demand.resp;
	assign icache.rdata = resp_q ? pf_line : arb_demand.rdata;

endmodule : next_line_prefetcher

// File: l1_mem_top.sv
`timescale 1ns/1ps

module l1_mem_top import l1_mem_pkg::*; (
	input logic clk,
	input logic rst_n,

	input logic icache_read,
	input rv32i_word icache_addr,
	output line_t icache_rdata,
	output logic icache_resp,

	input logic dcache_read,
	input logic dcache_write,
	input rv32i_word dcache_addr,
	input line_t dcache_wdata,
	output line_t dcache_rdata,
	output logic dcache_resp,

	output logic pmem_read,
	output logic pmem_write,
	output rv32i_word pmem_address,
	output line_t pmem_wdata,
	input line_t pmem_rdata,
	input logic pmem_resp
);

	mem_port_if icache_side ();
	mem_port_if dcache_side ();
	mem_port_if arb_i_demand ();
	mem_port_if arb_i_pre ();
	mem_port_if arb_d_write ();
	mem_port_if arb_d_read ();

	// icache only reads
	assign icache_side.read = icache_read;
	assign icache_side.write = 1'b0;
	assign icache_side.addr = icache_addr;
	assign icache_side.wdata = '0;
	assign icache_rdata = icache_side.rdata;
	assign icache_resp = icache_side.resp;

	assign dcache_side.read = dcache_read;
	assign dcache_side.write = dcache_write;
	assign dcache_side.addr = dcache_addr;
	assign dcache_side.wdata = dcache_wdata;
	assign dcache_rdata = dcache_side.rdata;
	assign dcache_resp = dcache_side.resp;

	next_line_prefetcher next_line_prefetcher_inst (
		.clk(clk),
		.rst_n(rst_n),
		.icache(icache_side.server),
		.arb_demand(arb_i_demand.requester),
		.arb_pre(arb_i_pre.requester)
	);

	eviction_write_buffer eviction_write_buffer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.dcache(dcache_side.server),
		.arb_write(arb_d_write.requester),
		.arb_read(arb_d_read.requester)
	);

	l1_arbiter l1_arbiter_inst (
		.clk(clk),
		.rst_n(rst_n),
		.i_demand(arb_i_demand.server),
		.i_pre(arb_i_pre.server),
		.d_write(arb_d_write.server),
		.d_read(arb_d_read.server),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp)
	);

endmodule : l1_mem_top

// File: l1_mem_properties.sv
`timescale 1ns/1ps

module l1_mem_properties import l1_mem_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic pmem_read,
	input logic pmem_write,
	input rv32i_word pmem_address,
	input logic [3:0] resp // i_demand, d_write, d_read, i_pre
);

	// memory sees one direction at a time
	one_direction: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high together");

	one_resp: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(resp))
		else $error("more than one arbiter response at once");

	resp_pulse: assert property (@(posedge clk) disable iff (!rst_n) |resp |=> !(|resp))
		else $error("arbiter response longer than one cycle");

	aligned_address: assert property (@(posedge clk) disable iff (!rst_n)
		(pmem_read || pmem_write) |-> pmem_address[OFFSET_BITS-1:0] == '0)
		else $error("memory address not line aligned");

endmodule : l1_mem_properties

bind l1_arbiter l1_mem_properties l1_mem_properties_inst (
	.clk(clk),
	.rst_n(rst_n),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_address(pmem_address),
	.resp({i_demand.resp, d_write.resp, d_read.resp, i_pre.resp})
);

// File: l1_mem_tb.sv
`timescale 1ns/1ps

module l1_mem_tb import l1_mem_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int NUM_RANDOM = 24;

	typedef logic [WORD_BITS-OFFSET_BITS-1:0] line_num_t;
	typedef enum logic [1:0] {src_mem, src_buf, src_pf, src_any} src_e;
	typedef struct {
		logic dport;  // 0 icache, 1 dcache
		logic write;
		logic settle; // let the memory port go idle first
		rv32i_word addr;
		line_t wdata;
		src_e src;
	} entry_t;

	logic clk = 1'b0;
	logic rst_n;
	logic icache_read, icache_resp;
	logic dcache_read, dcache_write, dcache_resp;
	logic pmem_read, pmem_write, pmem_resp;
	rv32i_word icache_addr, dcache_addr, pmem_address;
	line_t icache_rdata, dcache_wdata, dcache_rdata, pmem_wdata, pmem_rdata;

	line_t mem [line_num_t];    // memory model contents
	line_t shadow [line_num_t]; // latest value the caches wrote
	rv32i_word read_addrs [$];
	rv32i_word drain_addrs [$];
	line_t drain_lines [$];
	entry_t stim [$];
	logic [31:0] lfsr = 32'h1847_1a94;
	logic table_ready = 1'b0;
	logic busy;
	int wait_cnt;
	int mismatches = 0;
	int other_errors = 0;

	l1_mem_top l1_mem_top_inst (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic line_t random_line();
		line_t l;
		for (int w = 0; w < 8; w++)
			l[w*32 +: 32] = take_bits(32);
		return l;
	endfunction

	// unwritten lines hold their own word addresses, scrambled
	function automatic line_t fill_line(input line_num_t ln);
		line_t l;
		for (int w = 0; w < 8; w++)
			l[w*32 +: 32] = {ln, w[2:0], 2'b00} ^ 32'h6c3a_95e1;
		return l;
	endfunction

	function automatic line_t model_line(input line_num_t ln);
		return mem.exists(ln) ? mem[ln] : fill_line(ln);
	endfunction

	function automatic line_t expected_line(input rv32i_word a);
		return shadow.exists(a[31:OFFSET_BITS]) ? shadow[a[31:OFFSET_BITS]] :
			fill_line(a[31:OFFSET_BITS]);
	endfunction

	function automatic rv32i_word line_base(input rv32i_word a);
		return {a[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	endfunction

	task automatic check_value(input line_t got, input line_t exp, input string what);
		if (got !== exp) begin
			mismatches++;
			$display("[FAIL] %0d ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic store_line();
		if (drain_addrs.size() == 0) begin
			other_errors++;
			$display("memory write to %h with no write-back outstanding", pmem_address);
		end else begin
			check_value(pmem_address, drain_addrs.pop_front(), "write-back address");
			check_value(pmem_wdata, drain_lines.pop_front(), "write-back line");
		end
		mem[pmem_address[31:OFFSET_BITS]] = pmem_wdata;
	endtask

	// memory answers 1 to 4 cycles after it sees a request
	always @(negedge clk) begin
		if (!rst_n) begin
			busy = 1'b0;
			pmem_resp <= 1'b0;
		end else if (pmem_resp) begin
			pmem_resp <= 1'b0;
			busy = 1'b0;
		end else if (busy) begin
			if (wait_cnt > 0) begin
				wait_cnt--;
			end else begin
				pmem_resp <= 1'b1;
				if (pmem_read)
					pmem_rdata <= model_line(pmem_address[31:OFFSET_BITS]);
				else
					store_line();
			end
		end else if (pmem_read || pmem_write) begin
			busy = 1'b1;
			wait_cnt = take_bits(2);
			if (pmem_read)
				read_addrs.push_back(pmem_address);
		end
	end

	task automatic add_entry(input logic dport, input logic write, input logic settle,
			input rv32i_word addr, input line_t wdata, input src_e src);
		entry_t e;
		e = '{dport, write, settle, addr, wdata, src};
		stim.push_back(e);
	endtask

	task automatic build_table();
		logic [1:0] kind;
		rv32i_word addr;
		// demand miss, then the prefetched next line
		add_entry(0, 0, 1, 32'h0000_0104, '0, src_mem);
		add_entry(0, 0, 1, 32'h0000_0128, '0, src_pf);
		// write-back read from the buffer before its drain, then from memory
		add_entry(1, 1, 1, 32'h8000_0040, random_line(), src_any);
		add_entry(1, 0, 0, 32'h8000_0048, '0, src_buf);
		add_entry(1, 0, 1, 32'h8000_0050, '0, src_mem);
		add_entry(1, 1, 1, 32'h8000_0060, random_line(), src_any);
		add_entry(1, 1, 0, 32'h8000_0080, random_line(), src_any); // waits for the drain
		add_entry(1, 0, 1, 32'h8000_0070, '0, src_mem);
		add_entry(1, 0, 1, 32'h8000_009c, '0, src_mem);
		// icache stays in code space, dcache writes only data space
		for (int i = 0; i < NUM_RANDOM; i++) begin
			kind = take_bits(2);
			addr = take_bits(9);
			if (kind >= 2)
				add_entry(1, 1, 1, addr | 32'h8000_0000, random_line(), src_any);
			else if (kind == 1)
				add_entry(1, 0, 1, addr | (take_bits(1) << 31), '0, src_any);
			else
				add_entry(0, 0, 1, addr, '0, src_any);
		end
	endtask

	task automatic wait_quiet();
		int idle_cycles;
		idle_cycles = 0;
		while (idle_cycles < 4) begin
			@(negedge clk);
			if (pmem_read || pmem_write)
				idle_cycles = 0;
			else
				idle_cycles++;
		end
	endtask

	task automatic apply_entry(input entry_t e, input int idx);
		int reads_before;
		line_t got;
		if (e.settle)
			wait_quiet();
		@(negedge clk);
		reads_before = read_addrs.size();
		if (e.dport) begin
			dcache_addr = e.addr;
			dcache_wdata = e.wdata;
			dcache_read = !e.write;
			dcache_write = e.write;
		end else begin
			icache_addr = e.addr;
			icache_read = 1'b1;
		end
		do
			@(negedge clk);
		while (!(e.dport ? dcache_resp : icache_resp));
		got = e.dport ? dcache_rdata : icache_rdata;
		icache_read = 1'b0;
		dcache_read = 1'b0;
		dcache_write = 1'b0;
		if (e.write) begin
			shadow[e.addr[31:OFFSET_BITS]] = e.wdata;
			drain_addrs.push_back(line_base(e.addr));
			drain_lines.push_back(e.wdata);
		end else begin
			check_value(got, expected_line(e.addr), $sformatf("entry %0d read line", idx));
			if (e.src != src_any)
				check_value(read_addrs.size() - reads_before, e.src == src_mem,
					$sformatf("entry %0d memory reads", idx));
			if (e.src == src_mem || e.src == src_pf) // last fetch was this line
				check_value(read_addrs[$], line_base(e.addr),
					$sformatf("entry %0d memory read address", idx));
		end
	endtask

	// icache and dcache miss in the same cycle
	task automatic dual_read();
		int first;
		logic i_done;
		logic d_done;
		wait_quiet();
		@(negedge clk);
		first = read_addrs.size();
		i_done = 1'b0;
		d_done = 1'b0;
		icache_addr = 32'h0000_0a08;
		dcache_addr = 32'h8000_0044;
		icache_read = 1'b1;
		dcache_read = 1'b1;
		while (!(i_done && d_done)) begin
			@(negedge clk);
			if (icache_resp) begin
				check_value(icache_rdata, expected_line(icache_addr), "dual icache line");
				icache_read = 1'b0;
				i_done = 1'b1;
			end
			if (dcache_resp) begin
				check_value(dcache_rdata, expected_line(dcache_addr), "dual dcache line");
				dcache_read = 1'b0;
				d_done = 1'b1;
			end
		end
		check_value(read_addrs[first], 32'h0000_0a00, "first address of dual read");
	endtask

	initial begin
		wait (table_ready);
		#(stim.size() * 20 * CLK_PERIOD);
		$display("timeout: run still busy after %0d cycles", stim.size() * 20);
		$display("test failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		busy = 1'b0;
		icache_read = 1'b0;
		icache_addr = '0;
		dcache_read = 1'b0;
		dcache_write = 1'b0;
		dcache_addr = '0;
		dcache_wdata = '0;
		pmem_rdata <= '0;
		pmem_resp <= 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_value({icache_resp, dcache_resp, pmem_read, pmem_write}, '0, "idle outputs");
		end
		foreach (stim[i])
			apply_entry(stim[i], i);
		dual_read();
		wait_quiet();
		if (drain_addrs.size() != 0) begin
			other_errors++;
			$display("%0d write-backs never reached memory", drain_addrs.size());
		end
		$display("errors: %0d mismatches, %0d other", mismatches, other_errors);
		if (mismatches + other_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule : l1_mem_tb

// File: l1_mem.f
l1_mem_pkg.sv
mem_port_if.sv
l1_arbiter.sv
eviction_write_buffer.sv
next_line_prefetcher.sv
l1_mem_top.sv
l1_mem_properties.sv
l1_mem_tb.sv
